//--- cache_top.f
+incdir+test
hdl/cache_cfg_pkg.sv
hdl/cache_bus_pkg.sv
hdl/victim_select.sv
hdl/cache_ways.sv
hdl/linefill_buffer.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/cache_tb.sv

//--- hdl/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

  typedef struct packed {
    logic [cache_cfg_pkg::addr_width-1:0] addr;
    logic                                 rd;
    logic                                 wr;
    logic [cache_cfg_pkg::be_width-1:0]   be;
    logic [cache_cfg_pkg::data_width-1:0] wr_data;
  } cpu_req_t;

  typedef struct packed {
    logic [cache_cfg_pkg::addr_width-1:0] addr;
    logic                                 rd;
    logic                                 wr;
    logic [cache_cfg_pkg::data_width-1:0] wr_data;
  } mem_req_t;

  // install command from the linefill buffer to the ways
  typedef struct packed {
    logic                  install;
    cache_cfg_pkg::way_t   way;
    cache_cfg_pkg::index_t index;
    logic                  dirty;
    cache_cfg_pkg::tag_t   tag;
    cache_cfg_pkg::line_t  line;
  } fill_t;

  typedef enum logic {
    IDLE,
    WRITEBACK
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

  localparam int addr_width     = 32;
  localparam int data_width     = 32;
  localparam int be_width       = 4;
  localparam int line_words     = 4; // also the burst length
  localparam int num_sets       = 64;
  localparam int num_ways       = 4;
  localparam int index_width    = 6;
  localparam int word_sel_width = 2;
  localparam int byte_sel_width = 2;
  localparam int tag_width      = 22;
  localparam int way_width      = 2;

  localparam logic [10:0] lfsr_seed = 11'd101;

  typedef logic [tag_width-1:0]             tag_t;
  typedef logic [index_width-1:0]           index_t;
  typedef logic [word_sel_width-1:0]        word_sel_t;
  typedef logic [way_width-1:0]             way_t;
  typedef logic [line_words*data_width-1:0] line_t; // word 0 in the top bits

  typedef struct packed {
    logic valid;
    logic dirty;
    logic lfill; // line still filling, never hits
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

//--- hdl/cache_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module cache_ctrl (
  input  wire                                  clock,
  input  wire                                  reset_n,
  input  wire cache_bus_pkg::cpu_req_t         cpu_req,
  input  wire                                  way_hit,
  input  wire                                  lfill_hit,
  input  wire                                  busy,
  input  wire cache_cfg_pkg::tag_entry_t       sel_entry,
  input  wire cache_cfg_pkg::way_t             sel_way,
  input  wire [cache_cfg_pkg::data_width-1:0]  wb_data,
  input  wire                                  mem_waitrequest,
  output logic                                 cpu_rd_valid,
  output logic                                 cpu_waitrequest,
  output logic                                 cpu_write,
  output logic                                 alloc,
  output cache_cfg_pkg::way_t                  alloc_way,
  output logic                                 tag_write,
  output cache_cfg_pkg::tag_entry_t            new_tag,
  output logic                                 lfsr_step,
  output cache_cfg_pkg::word_sel_t             wb_word,
  output cache_bus_pkg::mem_req_t              mem_req
);

  localparam int low_bits = cache_cfg_pkg::word_sel_width + cache_cfg_pkg::byte_sel_width;

  cache_bus_pkg::ctrl_state_t state;
  cache_cfg_pkg::word_sel_t   wb_cnt;
  cache_cfg_pkg::tag_t        cpu_tag;
  cache_cfg_pkg::index_t      cpu_index;
  logic                       hit;
  logic                       miss;
  logic                       can_start;
  logic                       victim_dirty;
  logic                       start_wb;
  logic                       start_fill;
  logic                       wb_accept;
  logic                       wb_last;

  assign cpu_tag   = cpu_req.addr[cache_cfg_pkg::addr_width-1 -: cache_cfg_pkg::tag_width];
  assign cpu_index = cpu_req.addr[low_bits +: cache_cfg_pkg::index_width];

  assign hit             = way_hit | lfill_hit;
  assign miss            = (cpu_req.rd | cpu_req.wr) & ~hit;
  assign cpu_waitrequest = miss;
  assign cpu_rd_valid    = cpu_req.rd & hit;
  assign cpu_write       = cpu_req.wr & hit;

  // one linefill at a time
  assign can_start    = (state == cache_bus_pkg::IDLE) & miss & ~busy;
  assign victim_dirty = sel_entry.valid & sel_entry.dirty;
  assign start_wb     = can_start & victim_dirty;
  assign wb_accept    = (state == cache_bus_pkg::WRITEBACK) & mem_req.wr & ~mem_waitrequest;
  assign wb_last      = wb_accept
                      & (wb_cnt == cache_cfg_pkg::word_sel_t'(cache_cfg_pkg::line_words - 1));
  assign start_fill   = (can_start & ~victim_dirty) | wb_last;

  assign alloc     = start_fill;
  assign alloc_way = sel_way;
  assign lfsr_step = can_start & ~victim_dirty;
  assign tag_write = (cpu_write & ~lfill_hit) | start_wb | start_fill;

  // word to load into the write data register
  assign wb_word = (state == cache_bus_pkg::WRITEBACK)
                 ? cache_cfg_pkg::word_sel_t'(wb_cnt + 1'b1)
                 : '0;

  always_comb begin
    new_tag = sel_entry;
    if (start_fill)
      new_tag = '{valid: 1'b1, dirty: 1'b0, lfill: 1'b1, tag: cpu_tag};
    else if (start_wb)
      new_tag.valid = 1'b0; // invalid while the dirty line goes out
    else
      new_tag.dirty = 1'b1;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state   <= cache_bus_pkg::IDLE;
      wb_cnt  <= '0;
      mem_req <= '0;
    end else begin
      case (state)
        cache_bus_pkg::IDLE:      if (start_wb) state <= cache_bus_pkg::WRITEBACK;
        cache_bus_pkg::WRITEBACK: if (wb_last) state <= cache_bus_pkg::IDLE;
        default:                  state <= cache_bus_pkg::IDLE;
      endcase

      if (start_wb) begin
        mem_req.addr    <= {sel_entry.tag, cpu_index, {low_bits{1'b0}}};
        mem_req.wr      <= 1'b1;
        mem_req.wr_data <= wb_data;
        wb_cnt          <= '0;
      end else if (wb_accept) begin
        mem_req.addr    <= mem_req.addr + cache_cfg_pkg::be_width;
        mem_req.wr_data <= wb_data;
        wb_cnt          <= wb_cnt + 1'b1;
        if (wb_last)
          mem_req.wr <= 1'b0;
      end

      // fill address overrides the last writeback increment
      if (start_fill) begin
        mem_req.addr <= {cpu_req.addr[cache_cfg_pkg::addr_width-1:cache_cfg_pkg::byte_sel_width],
                         {cache_cfg_pkg::byte_sel_width{1'b0}}};
        mem_req.rd   <= 1'b1;
      end else if (!mem_waitrequest) begin
        mem_req.rd <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
`default_nettype none
`timescale 1ns/100ps

module cache_top (
  input  wire                                   clock,
  input  wire                                   reset_n,
  input  wire cache_bus_pkg::cpu_req_t          cpu_req,
  output logic                                  cpu_rd_valid,
  output logic [cache_cfg_pkg::data_width-1:0]  cpu_rd_data,
  output logic                                  cpu_waitrequest,
  output cache_bus_pkg::mem_req_t               mem_req,
  input  wire [cache_cfg_pkg::data_width-1:0]   mem_rd_data,
  input  wire                                   mem_rd_valid,
  input  wire                                   mem_waitrequest
);

  logic                                way_hit;
  cache_cfg_pkg::way_t                 sel_way;
  cache_cfg_pkg::tag_entry_t           sel_entry;
  logic                                lfill_hit;
  logic [cache_cfg_pkg::data_width-1:0] lfill_word;
  cache_bus_pkg::fill_t                fill;
  logic                                busy;
  logic                                cpu_write;
  logic                                alloc;
  cache_cfg_pkg::way_t                 alloc_way;
  logic                                tag_write;
  cache_cfg_pkg::tag_entry_t           new_tag;
  logic                                lfsr_step;
  cache_cfg_pkg::word_sel_t            wb_word;
  logic [cache_cfg_pkg::data_width-1:0] wb_data;
  logic [cache_cfg_pkg::data_width-1:0] cur_word;

  cache_ways u_ways (
    .clock       (clock),
    .reset_n     (reset_n),
    .cpu_req     (cpu_req),
    .cpu_write   (cpu_write),
    .tag_write   (tag_write),
    .new_tag     (new_tag),
    .lfsr_step   (lfsr_step),
    .wb_word     (wb_word),
    .fill        (fill),
    .lfill_hit   (lfill_hit),
    .lfill_word  (lfill_word),
    .way_hit     (way_hit),
    .sel_way     (sel_way),
    .sel_entry   (sel_entry),
    .cpu_rd_data (cpu_rd_data),
    .wb_data     (wb_data),
    .cur_word    (cur_word)
  );

  linefill_buffer u_lfill (
    .clock        (clock),
    .reset_n      (reset_n),
    .cpu_req      (cpu_req),
    .alloc        (alloc),
    .alloc_way    (alloc_way),
    .cpu_write    (cpu_write),
    .cur_word     (cur_word),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .busy         (busy),
    .lfill_hit    (lfill_hit),
    .lfill_word   (lfill_word),
    .fill         (fill)
  );

  cache_ctrl u_ctrl (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_req         (cpu_req),
    .way_hit         (way_hit),
    .lfill_hit       (lfill_hit),
    .busy            (busy),
    .sel_entry       (sel_entry),
    .sel_way         (sel_way),
    .wb_data         (wb_data),
    .mem_waitrequest (mem_waitrequest),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_waitrequest (cpu_waitrequest),
    .cpu_write       (cpu_write),
    .alloc           (alloc),
    .alloc_way       (alloc_way),
    .tag_write       (tag_write),
    .new_tag         (new_tag),
    .lfsr_step       (lfsr_step),
    .wb_word         (wb_word),
    .mem_req         (mem_req)
  );

endmodule

`default_nettype wire

//--- hdl/cache_ways.sv
`default_nettype none
`timescale 1ns/100ps

module cache_ways (
  input  wire                                  clock,
  input  wire                                  reset_n,
  input  wire cache_bus_pkg::cpu_req_t         cpu_req,
  input  wire                                  cpu_write,
  input  wire                                  tag_write,
  input  wire cache_cfg_pkg::tag_entry_t       new_tag,
  input  wire                                  lfsr_step,
  input  wire cache_cfg_pkg::word_sel_t        wb_word,
  input  wire cache_bus_pkg::fill_t            fill,
  input  wire                                  lfill_hit,
  input  wire [cache_cfg_pkg::data_width-1:0]  lfill_word,
  output logic                                 way_hit,
  output cache_cfg_pkg::way_t                  sel_way,
  output cache_cfg_pkg::tag_entry_t            sel_entry,
  output logic [cache_cfg_pkg::data_width-1:0] cpu_rd_data,
  output logic [cache_cfg_pkg::data_width-1:0] wb_data,
  output logic [cache_cfg_pkg::data_width-1:0] cur_word
);

  localparam int dw = cache_cfg_pkg::data_width;
  localparam int nw = cache_cfg_pkg::num_ways;

  cache_cfg_pkg::tag_entry_t tag_mem [nw][cache_cfg_pkg::num_sets];
  cache_cfg_pkg::line_t      data_mem [nw][cache_cfg_pkg::num_sets];

  cache_cfg_pkg::tag_entry_t [nw-1:0] entries;
  logic [nw-1:0]             hit;
  cache_cfg_pkg::way_t       victim;
  cache_cfg_pkg::tag_t       tag;
  cache_cfg_pkg::index_t     index;
  cache_cfg_pkg::word_sel_t  word;
  logic [dw-1:0]             way_word;
  logic [dw-1:0]             be_mask;
  cache_cfg_pkg::line_t      fill_line;

  assign tag   = cpu_req.addr[cache_cfg_pkg::addr_width-1 -: cache_cfg_pkg::tag_width];
  assign index = cpu_req.addr[cache_cfg_pkg::byte_sel_width + cache_cfg_pkg::word_sel_width
                              +: cache_cfg_pkg::index_width];
  assign word  = cpu_req.addr[cache_cfg_pkg::byte_sel_width +: cache_cfg_pkg::word_sel_width];

  for (genvar w = 0; w < nw; w++) begin : g_way
    assign entries[w] = tag_mem[w][index];
    assign hit[w]     = entries[w].valid & ~entries[w].lfill & (entries[w].tag == tag);
  end

  for (genvar b = 0; b < cache_cfg_pkg::be_width; b++) begin : g_be
    assign be_mask[8*b +: 8] = {8{cpu_req.be[b]}};
  end

  victim_select u_victim (
    .clock   (clock),
    .reset_n (reset_n),
    .step    (lfsr_step),
    .entries (entries),
    .victim  (victim)
  );

  // hit way wins over the victim
  always_comb begin
    sel_way = victim;
    for (int w = nw - 1; w >= 0; w--)
      if (hit[w])
        sel_way = cache_cfg_pkg::way_t'(w);
  end

  assign way_hit   = |hit;
  assign sel_entry = entries[sel_way];

  assign way_word    = data_mem[sel_way][index][(cache_cfg_pkg::line_words-1-word)*dw +: dw];
  assign cpu_rd_data = lfill_hit ? lfill_word : way_word;
  assign cur_word    = (cpu_rd_data & ~be_mask) | (cpu_req.wr_data & be_mask);
  assign wb_data     = data_mem[sel_way][index][(cache_cfg_pkg::line_words-1-wb_word)*dw +: dw];

  // write landing on the line being installed
  always_comb begin
    fill_line = fill.line;
    if (cpu_write && lfill_hit)
      fill_line[(cache_cfg_pkg::line_words-1-word)*dw +: dw] = cur_word;
  end

  always_ff @(posedge clock) begin
    if (cpu_write && !lfill_hit)
      data_mem[sel_way][index][(cache_cfg_pkg::line_words-1-word)*dw +: dw] <= cur_word;
    if (fill.install)
      data_mem[fill.way][fill.index] <= fill_line;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      for (int w = 0; w < nw; w++)
        for (int s = 0; s < cache_cfg_pkg::num_sets; s++)
          tag_mem[w][s] <= '0;
    end else begin
      if (tag_write)
        tag_mem[sel_way][index] <= new_tag;
      if (fill.install)
        tag_mem[fill.way][fill.index] <= '{valid: 1'b1,
                                           dirty: fill.dirty | (cpu_write & lfill_hit),
                                           lfill: 1'b0,
                                           tag:   fill.tag};
    end
  end

endmodule

`default_nettype wire

//--- hdl/linefill_buffer.sv
`default_nettype none
`timescale 1ns/100ps

module linefill_buffer (
  input  wire                                  clock,
  input  wire                                  reset_n,
  input  wire cache_bus_pkg::cpu_req_t         cpu_req,
  input  wire                                  alloc,
  input  wire cache_cfg_pkg::way_t             alloc_way,
  input  wire                                  cpu_write,
  input  wire [cache_cfg_pkg::data_width-1:0]  cur_word,
  input  wire [cache_cfg_pkg::data_width-1:0]  mem_rd_data,
  input  wire                                  mem_rd_valid,
  output logic                                 busy,
  output logic                                 lfill_hit,
  output logic [cache_cfg_pkg::data_width-1:0] lfill_word,
  output cache_bus_pkg::fill_t                 fill
);

  localparam int dw = cache_cfg_pkg::data_width;
  localparam int lw = cache_cfg_pkg::line_words;

  logic [lw-1:0]            valid;
  logic                     dirty;
  cache_cfg_pkg::tag_t      tag;
  cache_cfg_pkg::index_t    index;
  cache_cfg_pkg::way_t      way;
  cache_cfg_pkg::word_sel_t mem_idx; // next word of the burst
  cache_cfg_pkg::line_t     line;
  cache_cfg_pkg::tag_t      cpu_tag;
  cache_cfg_pkg::index_t    cpu_index;
  cache_cfg_pkg::word_sel_t cpu_word;
  logic                     all_valid;

  assign cpu_tag   = cpu_req.addr[cache_cfg_pkg::addr_width-1 -: cache_cfg_pkg::tag_width];
  assign cpu_index = cpu_req.addr[cache_cfg_pkg::byte_sel_width + cache_cfg_pkg::word_sel_width
                                  +: cache_cfg_pkg::index_width];
  assign cpu_word  = cpu_req.addr[cache_cfg_pkg::byte_sel_width +: cache_cfg_pkg::word_sel_width];

  assign all_valid  = &valid;
  assign lfill_hit  = valid[cpu_word] & (tag == cpu_tag) & (index == cpu_index);
  assign lfill_word = line[(lw-1-cpu_word)*dw +: dw];

  assign fill = '{install: all_valid, way: way, index: index, dirty: dirty, tag: tag, line: line};

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      valid <= '0;
      dirty <= 1'b0;
      busy  <= 1'b0;
    end else if (alloc) begin
      valid <= '0;
      dirty <= 1'b0;
      busy  <= 1'b1;
    end else if (all_valid) begin // install cycle
      valid <= '0;
      dirty <= 1'b0;
      busy  <= 1'b0;
    end else begin
      if (mem_rd_valid)
        valid[mem_idx] <= 1'b1;
      if (cpu_write && lfill_hit)
        dirty <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      tag     <= cpu_tag;
      index   <= cpu_index;
      way     <= alloc_way;
      mem_idx <= cpu_word; // critical word first
    end else if (mem_rd_valid) begin
      mem_idx <= mem_idx + 1'b1; // wraps within the line
    end
    if (mem_rd_valid)
      line[(lw-1-mem_idx)*dw +: dw] <= mem_rd_data;
    if (cpu_write && lfill_hit && !all_valid)
      line[(lw-1-cpu_word)*dw +: dw] <= cur_word;
  end

endmodule

`default_nettype wire

//--- hdl/victim_select.sv
`default_nettype none
`timescale 1ns/100ps

module victim_select (
  input  wire                                                clock,
  input  wire                                                reset_n,
  input  wire                                                step,
  input  wire cache_cfg_pkg::tag_entry_t [cache_cfg_pkg::num_ways-1:0] entries,
  output cache_cfg_pkg::way_t                                victim
);

  logic [10:0]         lfsr;
  cache_cfg_pkg::way_t rand_way;

  // x^11 + x^9 + 1 leaped two bits per step
  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n)
      lfsr <= cache_cfg_pkg::lfsr_seed;
    else if (step)
      lfsr <= {lfsr[1] ^ lfsr[3], lfsr[0] ^ lfsr[2], lfsr[10:2]};
  end

  assign rand_way = lfsr[1:0];

  always_comb begin
    cache_cfg_pkg::way_t idx;
    logic                found;
    found  = 1'b0;
    victim = rand_way; // all dirty
    idx    = rand_way;
    for (int w = 0; w < cache_cfg_pkg::num_ways; w++)
      if (!found && !entries[w].valid && !entries[w].lfill) begin
        victim = cache_cfg_pkg::way_t'(w);
        found  = 1'b1;
      end
    // clean ways start after the random one
    for (int k = 1; k < cache_cfg_pkg::num_ways; k++) begin
      idx = rand_way + cache_cfg_pkg::way_t'(k);
      if (!found && !entries[idx].dirty && !entries[idx].lfill) begin
        victim = idx;
        found  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds and runs the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cache_tb -f cache_top.f \
  -o cache_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

//--- test/cache_model.svh
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// expected memory over the test window
logic [31:0] exp_mem [win_words];
int          checks;
int          errors;

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// initial memory contents keyed on the word address
function automatic logic [31:0] fill_pattern(input int idx);
  return xorshift(32'h6b5f_1c00 + 32'(idx));
endfunction

task automatic model_init;
  int i;
  for (i = 0; i < win_words; i++)
    exp_mem[i] = fill_pattern(i);
  checks = 0;
  errors = 0;
endtask

task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
  logic [31:0] w;
  int          b;
  w = exp_mem[addr[13:2]];
  for (b = 0; b < 4; b++)
    if (be[b])
      w[8*b +: 8] = data[8*b +: 8]; // only enabled bytes change
  exp_mem[addr[13:2]] = w;
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

`endif

//--- test/cache_tb.sv
`default_nettype none
`timescale 1ns/100ps

module cache_tb;

  localparam int clk_period   = 100;
  localparam int num_random   = 400;
  localparam int num_accesses = num_random + 40;
  localparam int win_words    = 4096; // 16 KB window

  logic                                 clock;
  logic                                 reset_n;
  cache_bus_pkg::cpu_req_t              cpu_req;
  logic                                 cpu_rd_valid;
  logic [cache_cfg_pkg::data_width-1:0] cpu_rd_data;
  logic                                 cpu_waitrequest;
  cache_bus_pkg::mem_req_t              mem_req;
  logic [cache_cfg_pkg::data_width-1:0] mem_rd_data;
  logic                                 mem_rd_valid;
  logic                                 mem_waitrequest;

  logic [31:0] back_mem [win_words];
  logic [31:0] stim_rng;
  logic [31:0] mem_rng;
  logic        slow_mem;
  int          burst_left;
  logic [31:0] burst_addr;
  int          gap;
  int          wb_pos;
  logic [31:0] wb_base;
  int          wb_words;
  int          rd_bursts;
  logic [31:0] last_rd_addr;

  `include "cache_model.svh"

  cache_top UUT (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_req         (cpu_req),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .mem_req         (mem_req),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest)
  );

  task automatic next_rand(output logic [31:0] v);
    stim_rng = xorshift(stim_rng);
    v = stim_rng;
  endtask

  // drive one access and hold it until cpu_waitrequest drops
  task automatic access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                        input logic [31:0] data, output logic [31:0] rdata, output int stall);
    @(negedge clock);
    cpu_req.addr    = addr;
    cpu_req.rd      = ~wr;
    cpu_req.wr      = wr;
    cpu_req.be      = be;
    cpu_req.wr_data = data;
    stall = 0;
    #(clk_period/4);
    while (cpu_waitrequest) begin
      stall++;
      @(negedge clock);
      #(clk_period/4);
    end
    rdata = cpu_rd_data;
    if (!wr)
      check("cpu_rd_valid", 32'(cpu_rd_valid), 32'd1);
    @(posedge clock); // access completes here
  endtask

  task automatic read_word(input logic [31:0] addr, output int stall);
    logic [31:0] rdata;
    access(1'b0, addr, 4'hf, 32'd0, rdata, stall);
    check("cpu_rd_data", rdata, exp_mem[addr[13:2]]);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
    logic [31:0] rdata;
    int          stall;
    access(1'b1, addr, be, data, rdata, stall);
    model_write(addr, be, data);
  endtask

  task automatic idle_cycles(input int n);
    @(negedge clock);
    cpu_req.rd = 1'b0;
    cpu_req.wr = 1'b0;
    repeat (n) @(negedge clock);
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s: %0d errors (%0d checks so far)", name, errors - err_start, checks);
  endtask

  initial begin
    clock = 1'b0;
    forever #(clk_period/2) clock = ~clock;
  end

  initial begin
    #(num_accesses * 60 * clk_period);
    $display("timeout: the accesses did not finish in the time allowed");
    $display("ERRORS FOUND");
    $finish;
  end

  // memory side with random back-pressure and gaps between burst words
  initial begin
    logic [31:0] r;
    @(posedge reset_n);
    forever begin
      @(negedge clock);
      mem_rng = xorshift(mem_rng);
      r = mem_rng;
      mem_rd_valid = 1'b0;
      if (burst_left > 0) begin
        if (gap > 0) begin
          gap--;
        end else begin
          mem_rd_valid    = 1'b1;
          mem_rd_data     = back_mem[burst_addr[13:2]];
          burst_addr[3:2] = burst_addr[3:2] + 2'd1; // wraps in the line
          burst_left--;
          gap = int'(r[9:8]) + (slow_mem ? 4 : 0);
        end
      end
      mem_waitrequest = (r[1:0] == 2'b00);
      if (!mem_waitrequest && mem_req.rd) begin
        check("mem_req.addr", mem_req.addr, {cpu_req.addr[31:2], 2'b00});
        last_rd_addr = mem_req.addr;
        rd_bursts++;
        burst_left = cache_cfg_pkg::line_words;
        burst_addr = mem_req.addr;
        gap = int'(r[9:8]) + (slow_mem ? 4 : 0);
      end
      if (!mem_waitrequest && mem_req.wr) begin
        check("mem_req.addr[31:14]", 32'(mem_req.addr[31:14]), 32'd0);
        if (wb_pos == 0) begin
          check("mem_req.addr[3:0]", 32'(mem_req.addr[3:0]), 32'd0);
          wb_base = mem_req.addr;
        end else begin
          check("mem_req.addr", mem_req.addr, wb_base + 32'(4 * wb_pos));
        end
        check("mem_req.wr_data", mem_req.wr_data, exp_mem[mem_req.addr[13:2]]);
        back_mem[mem_req.addr[13:2]] = mem_req.wr_data;
        wb_pos = (wb_pos + 1) % cache_cfg_pkg::line_words;
        wb_words++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] a;
    int          i;
    int          stall;
    int          err_start;
    int          wb_start;
    int          rd_start;
    reset_n         = 1'b0;
    cpu_req         = '0;
    mem_rd_data     = '0;
    mem_rd_valid    = 1'b0;
    mem_waitrequest = 1'b0;
    stim_rng   = 32'hd9a0_040e;
    mem_rng    = ~32'hd9a0_040e; // separate stream for the memory side
    slow_mem   = 1'b0;
    burst_left = 0;
    burst_addr = '0;
    gap        = 0;
    wb_pos     = 0;
    wb_base    = '0;
    wb_words   = 0;
    rd_bursts  = 0;
    last_rd_addr = '0;
    model_init;
    for (i = 0; i < win_words; i++)
      back_mem[i] = fill_pattern(i);
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;

    err_start = errors;
    repeat (8) begin
      @(negedge clock);
      #(clk_period/4);
      check("mem_req.rd", 32'(mem_req.rd), 32'd0);
      check("mem_req.wr", 32'(mem_req.wr), 32'd0);
      check("cpu_waitrequest", 32'(cpu_waitrequest), 32'd0);
    end
    report_test("test 1 reset and idle", err_start);

    err_start = errors;
    rd_start  = rd_bursts;
    read_word(32'h0000_0124, stall);
    check("memory read bursts", 32'(rd_bursts - rd_start), 32'd1);
    check("mem_req.addr", last_rd_addr, 32'h0000_0124);
    report_test("test 2 read miss", err_start);

    err_start = errors;
    idle_cycles(20);
    read_word(32'h0000_0124, stall);
    check("cpu_waitrequest cycles", 32'(stall), 32'd0);
    read_word(32'h0000_0128, stall);
    check("cpu_waitrequest cycles", 32'(stall), 32'd0);
    report_test("test 3 zero-latency hit", err_start);

    err_start = errors;
    next_rand(d);
    write_word(32'h0000_0a38, 4'b0101, d);
    read_word(32'h0000_0a38, stall);
    next_rand(d);
    write_word(32'h0000_0a38, 4'b1010, d);
    read_word(32'h0000_0a38, stall);
    slow_mem = 1'b1; // long gaps keep the line in the buffer
    read_word(32'h0000_1d40, stall);
    next_rand(d);
    write_word(32'h0000_1d40, 4'b0011, d);
    check("burst words left", 32'(burst_left > 0), 32'd1);
    next_rand(d);
    write_word(32'h0000_1d44, 4'b1100, d);
    next_rand(d);
    write_word(32'h0000_1d4c, 4'b1111, d);
    slow_mem = 1'b0;
    idle_cycles(40);
    for (i = 0; i < 4; i++)
      read_word(32'h0000_1d40 + 32'(4 * i), stall);
    report_test("test 4 byte writes", err_start);

    err_start = errors;
    wb_start  = wb_words;
    for (i = 0; i < 5; i++) begin
      next_rand(d);
      write_word(32'(i * 1024) + 32'h0000_0300 + 32'(4 * (i % 4)), 4'hf, d);
    end
    check("writeback words", 32'(wb_words - wb_start), 32'd4);
    for (i = 0; i < 5; i++)
      read_word(32'(i * 1024) + 32'h0000_0300 + 32'(4 * (i % 4)), stall);
    report_test("test 5 dirty eviction", err_start);

    err_start = errors;
    for (i = 0; i < num_random; i++) begin
      next_rand(r);
      next_rand(d);
      a = {18'd0, r[13:2], 2'b00};
      if (r[31])
        write_word(a, r[17:14], d);
      else
        read_word(a, stall);
      if (r[30:28] == 3'd0)
        idle_cycles(1 + int'(r[27:26]));
    end
    report_test("test 6 random mix", err_start);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire
